// File: source/cmdproc_settings.svh
// Host command processor constants
// Frame length, SPI timing and the fixed reply codes

`ifndef CMDPROC_SETTINGS_SVH
`define CMDPROC_SETTINGS_SVH

// --------------------------------------------------
// command frame
`define FRAME_BYTES      8

// --------------------------------------------------
// reply codes
`define FW_VERSION       11
`define PLL_RESET_ACK    33
`define UNUSED_ACK       19

// --------------------------------------------------
// SPI side
`define CS_SETUP_CYCLES  6   // clocks with cs low before first byte
`define CS_HOLD_CYCLES   16  // clocks after read-back before reply
`define SPI_CHIPS        8

`endif

// File: source/cmdproc_pkg.sv
// Host command processor types
// Data widths, frame layout, opcodes and FSM states

package cmdproc_pkg;

	typedef logic [7:0]  byte_t;
	typedef logic [31:0] word_t;
	typedef logic [2:0]  chip_t;

	typedef byte_t [7:0] frame_t; // index 0 is the opcode byte

	typedef enum logic [7:0] {
		OP_PLL_RESET = 8'd1,
		OP_VERSION   = 8'd2,
		OP_SPI       = 8'd3,
		OP_UNUSED    = 8'd4
	} opcode_e;

	typedef enum logic [1:0] {
		D_IDLE,
		D_SPI_WAIT,
		D_REPLY
	} disp_state_e;

	typedef enum logic [2:0] {
		S_IDLE,
		S_SETUP,
		S_WAIT_READY,
		S_STROBE,
		S_WAIT_RX,
		S_HOLD
	} spi_state_e;

endpackage

// File: source/frame_receiver.sv
// Frame receiver
// Collects command bytes from the input stream into one frame,
// then stalls the stream until the dispatcher releases the frame.

`timescale 1ns/1ps
`include "cmdproc_settings.svh"

module frame_receiver (
	input  logic                clk,
	input  logic                rstn,
	input  logic                i_in_valid,
	input  cmdproc_pkg::byte_t  i_in_data,
	input  logic                i_release,
	output logic                o_in_ready,
	output logic                o_frame_valid,
	output cmdproc_pkg::frame_t o_frame
);
	import cmdproc_pkg::*;

	localparam int CNT_W = $clog2(`FRAME_BYTES);

	logic [CNT_W-1:0] byte_cnt;
	logic             accept;
	frame_t           frame_q;

	assign o_in_ready = !o_frame_valid; // stalled while a frame is held
	assign accept     = i_in_valid && o_in_ready;
	assign o_frame    = frame_q;

	always_ff @(posedge clk or negedge rstn) begin
		if (!rstn) begin
			byte_cnt      <= '0;
			o_frame_valid <= 1'b0;
		end else if (accept) begin
			if (byte_cnt == CNT_W'(`FRAME_BYTES - 1)) begin
				byte_cnt      <= '0;
				o_frame_valid <= 1'b1; // last byte in
			end else begin
				byte_cnt <= byte_cnt + 1'b1;
			end
		end else if (i_release) begin
			o_frame_valid <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (accept) begin
			frame_q[byte_cnt] <= i_in_data;
		end
	end

	// held frame must not move under the dispatcher
	a_frame_stable : assert property (
		@(posedge clk) disable iff (!rstn)
		o_frame_valid && !i_release |=> $stable(o_frame)
	);

endmodule

// File: source/spi_sequencer.sv
// SPI sequencer
// Drives one SPI transaction: selects the chip, waits for setup,
// strobes 2 to 4 bytes out as the serializer becomes ready, takes
// the read-back byte and holds chip select before finishing.

`timescale 1ns/1ps
`include "cmdproc_settings.svh"

module spi_sequencer (
	input  logic                     clk,
	input  logic                     rstn,
	input  logic                     i_start,
	input  cmdproc_pkg::chip_t       i_chip,
	input  cmdproc_pkg::byte_t       i_count,
	input  cmdproc_pkg::byte_t [3:0] i_tx_bytes,
	input  logic                     i_spi_tx_ready,
	input  logic                     i_spi_rx_dv,
	input  cmdproc_pkg::byte_t       i_spi_rx,
	output logic [`SPI_CHIPS-1:0]    o_spi_cs,
	output cmdproc_pkg::chip_t       o_miso_sel,
	output cmdproc_pkg::byte_t       o_spi_tx,
	output logic                     o_spi_tx_dv,
	output logic                     o_done,
	output cmdproc_pkg::byte_t       o_rx_byte
);
	import cmdproc_pkg::*;

	localparam int NCS   = `SPI_CHIPS;
	localparam int TMR_W = $clog2(`CS_HOLD_CYCLES + 1);

	spi_state_e       state;
	logic [TMR_W-1:0] timer;
	logic [1:0]       idx;
	logic             two_byte;
	logic             four_byte;
	logic             last_byte;
	byte_t [3:0]      tx_bytes;

	// count 2 skips the middle byte, count 4 adds the fourth
	assign last_byte   = four_byte ? (idx == 2'd3) : (idx == 2'd2);
	assign o_spi_tx    = tx_bytes[idx];
	assign o_spi_tx_dv = (state == S_WAIT_READY) && i_spi_tx_ready;

	// --------------------------------------------------
	// control
	always_ff @(posedge clk or negedge rstn) begin
		if (!rstn) begin
			state      <= S_IDLE;
			timer      <= '0;
			idx        <= '0;
			o_spi_cs   <= '1;
			o_miso_sel <= '0;
			o_done     <= 1'b0;
		end else begin
			o_done <= 1'b0;
			case (state)
			S_IDLE: if (i_start) begin
				o_spi_cs   <= ~(NCS'(1) << i_chip); // one line low
				o_miso_sel <= i_chip;
				timer      <= '0;
				idx        <= '0;
				state      <= S_SETUP;
			end
			S_SETUP: begin
				if (timer == TMR_W'(`CS_SETUP_CYCLES - 1)) begin
					timer <= '0;
					state <= S_WAIT_READY;
				end else begin
					timer <= timer + 1'b1;
				end
			end
			S_WAIT_READY: if (i_spi_tx_ready) begin
				state <= S_STROBE; // strobe went out this cycle
			end
			S_STROBE: begin
				if (last_byte) begin
					state <= S_WAIT_RX;
				end else begin
					idx   <= (two_byte && idx == 2'd0) ? 2'd2 : idx + 2'd1;
					state <= S_WAIT_READY;
				end
			end
			S_WAIT_RX: if (i_spi_rx_dv) begin
				timer <= '0;
				state <= S_HOLD;
			end
			S_HOLD: begin
				if (timer == TMR_W'(`CS_HOLD_CYCLES - 1)) begin
					o_spi_cs <= '1;
					o_done   <= 1'b1;
					state    <= S_IDLE;
				end else begin
					timer <= timer + 1'b1;
				end
			end
			default: state <= S_IDLE;
			endcase
		end
	end

	// --------------------------------------------------
	// transaction data
	always_ff @(posedge clk) begin
		if (state == S_IDLE && i_start) begin
			tx_bytes  <= i_tx_bytes;
			two_byte  <= (i_count == 8'd2);
			four_byte <= (i_count == 8'd4); // anything else sends 3
		end
		if (state == S_WAIT_RX && i_spi_rx_dv) begin
			o_rx_byte <= i_spi_rx;
		end
	end

	a_tx_dv_single : assert property (
		@(posedge clk) disable iff (!rstn)
		o_spi_tx_dv |=> !o_spi_tx_dv
	);

	// at most one chip selected, and it is the one being listened to
	a_cs_onehot : assert property (
		@(posedge clk) disable iff (!rstn)
		!(&o_spi_cs) |-> $onehot(~o_spi_cs) && !o_spi_cs[o_miso_sel]
	);

endmodule

// File: source/cmd_dispatch.sv
// Command dispatcher
// Decodes the opcode of a held frame, pulses the PLL reset, hands
// SPI commands to the sequencer and loads one reply word per command.
// The frame is released once its reply has left the output stream.

`timescale 1ns/1ps
`include "cmdproc_settings.svh"

module cmd_dispatch (
	input  logic                     clk,
	input  logic                     rstn,
	input  logic                     i_frame_valid,
	input  cmdproc_pkg::frame_t      i_frame,
	input  logic                     i_spi_done,
	input  cmdproc_pkg::byte_t       i_spi_rx_byte,
	input  logic                     i_reply_busy,
	output logic                     o_release,
	output logic                     o_pll_reset,
	output logic                     o_spi_start,
	output cmdproc_pkg::chip_t       o_spi_chip,
	output cmdproc_pkg::byte_t       o_spi_count,
	output cmdproc_pkg::byte_t [3:0] o_spi_bytes,
	output logic                     o_reply_load,
	output cmdproc_pkg::word_t       o_reply_word
);
	import cmdproc_pkg::*;

	disp_state_e state;
	opcode_e     opcode;
	logic        decode;

	assign opcode = opcode_e'(i_frame[0]);
	assign decode = i_frame_valid && !o_release; // frame still up during release

	// frame is stable while held, so the sequencer args come straight off it
	assign o_spi_chip  = chip_t'(i_frame[1][2:0]);
	assign o_spi_count = i_frame[7];
	assign o_spi_bytes = i_frame[5:2];

	always_ff @(posedge clk or negedge rstn) begin
		if (!rstn) begin
			state        <= D_IDLE;
			o_release    <= 1'b0;
			o_pll_reset  <= 1'b0;
			o_spi_start  <= 1'b0;
			o_reply_load <= 1'b0;
		end else begin
			o_release    <= 1'b0;
			o_pll_reset  <= 1'b0;
			o_spi_start  <= 1'b0;
			o_reply_load <= 1'b0;
			case (state)
			D_IDLE: if (decode) begin
				case (opcode)
				OP_PLL_RESET: begin
					o_pll_reset  <= 1'b1;
					o_reply_load <= 1'b1;
					state        <= D_REPLY;
				end
				OP_VERSION, OP_UNUSED: begin
					o_reply_load <= 1'b1;
					state        <= D_REPLY;
				end
				OP_SPI: begin
					o_spi_start <= 1'b1;
					state       <= D_SPI_WAIT;
				end
				default: o_release <= 1'b1; // unknown opcode is dropped
				endcase
			end
			D_SPI_WAIT: if (i_spi_done) begin
				o_reply_load <= 1'b1;
				state        <= D_REPLY;
			end
			D_REPLY: if (!i_reply_busy && !o_reply_load) begin
				o_release <= 1'b1; // word accepted
				state     <= D_IDLE;
			end
			default: state <= D_IDLE;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (state == D_SPI_WAIT && i_spi_done) begin
			o_reply_word <= word_t'(i_spi_rx_byte); // zero-extended
		end else if (state == D_IDLE && decode) begin
			case (opcode)
			OP_PLL_RESET: o_reply_word <= word_t'(`PLL_RESET_ACK);
			OP_VERSION:   o_reply_word <= word_t'(`FW_VERSION);
			OP_UNUSED:    o_reply_word <= word_t'(`UNUSED_ACK);
			default:      o_reply_word <= o_reply_word;
			endcase
		end
	end

	a_release_held : assert property (
		@(posedge clk) disable iff (!rstn)
		o_release |-> i_frame_valid
	);

endmodule

// File: source/reply_sender.sv
// Reply sender
// One-word output register on the reply stream. The word is held
// with valid raised until the consumer takes it.

`timescale 1ns/1ps

module reply_sender (
	input  logic               clk,
	input  logic               rstn,
	input  logic               i_reply_load,
	input  cmdproc_pkg::word_t i_reply_word,
	input  logic               i_out_ready,
	output logic               o_out_valid,
	output cmdproc_pkg::word_t o_out_data
);
	import cmdproc_pkg::*;

	word_t data_q;

	assign o_out_data = data_q;

	always_ff @(posedge clk or negedge rstn) begin
		if (!rstn) begin
			o_out_valid <= 1'b0;
		end else if (i_reply_load) begin
			o_out_valid <= 1'b1;
		end else if (i_out_ready) begin
			o_out_valid <= 1'b0; // taken
		end
	end

	always_ff @(posedge clk) begin
		if (i_reply_load) begin
			data_q <= i_reply_word;
		end
	end

	a_hold_until_ready : assert property (
		@(posedge clk) disable iff (!rstn)
		o_out_valid && !i_out_ready |=> o_out_valid && $stable(o_out_data)
	);

	// only one command in flight, so no load on a busy register
	a_no_overwrite : assert property (
		@(posedge clk) disable iff (!rstn)
		i_reply_load |-> !o_out_valid
	);

endmodule

// File: source/cmdproc_top.sv
// Host command processor top level
// Frame receiver, command dispatcher, SPI sequencer and reply
// sender on one clock

`timescale 1ns/1ps
`include "cmdproc_settings.svh"

module cmdproc_top (
	input  logic                  clk,
	input  logic                  rstn,
	input  logic                  i_in_valid,
	input  cmdproc_pkg::byte_t    i_in_data,
	output logic                  o_in_ready,
	input  logic                  i_out_ready,
	output logic                  o_out_valid,
	output cmdproc_pkg::word_t    o_out_data,
	output logic                  o_pll_reset,
	output logic [`SPI_CHIPS-1:0] o_spi_cs,
	output cmdproc_pkg::chip_t    o_miso_sel,
	output cmdproc_pkg::byte_t    o_spi_tx,
	output logic                  o_spi_tx_dv,
	input  logic                  i_spi_tx_ready,
	input  logic                  i_spi_rx_dv,
	input  cmdproc_pkg::byte_t    i_spi_rx
);
	import cmdproc_pkg::*;

	logic        frame_valid;
	logic        frame_release;
	frame_t      frame;
	logic        spi_start;
	chip_t       spi_chip;
	byte_t       spi_count;
	byte_t [3:0] spi_bytes;
	logic        spi_done;
	byte_t       spi_rx_byte;
	logic        reply_load;
	word_t       reply_word;

	// --------------------------------------------------
	frame_receiver u_rx (
		.clk           (clk),
		.rstn          (rstn),
		.i_in_valid    (i_in_valid),
		.i_in_data     (i_in_data),
		.i_release     (frame_release),
		.o_in_ready    (o_in_ready),
		.o_frame_valid (frame_valid),
		.o_frame       (frame)
	);

	cmd_dispatch u_disp (
		.clk           (clk),
		.rstn          (rstn),
		.i_frame_valid (frame_valid),
		.i_frame       (frame),
		.i_spi_done    (spi_done),
		.i_spi_rx_byte (spi_rx_byte),
		.i_reply_busy  (o_out_valid), // sender valid doubles as busy
		.o_release     (frame_release),
		.o_pll_reset   (o_pll_reset),
		.o_spi_start   (spi_start),
		.o_spi_chip    (spi_chip),
		.o_spi_count   (spi_count),
		.o_spi_bytes   (spi_bytes),
		.o_reply_load  (reply_load),
		.o_reply_word  (reply_word)
	);

	spi_sequencer u_spi (
		.clk            (clk),
		.rstn           (rstn),
		.i_start        (spi_start),
		.i_chip         (spi_chip),
		.i_count        (spi_count),
		.i_tx_bytes     (spi_bytes),
		.i_spi_tx_ready (i_spi_tx_ready),
		.i_spi_rx_dv    (i_spi_rx_dv),
		.i_spi_rx       (i_spi_rx),
		.o_spi_cs       (o_spi_cs),
		.o_miso_sel     (o_miso_sel),
		.o_spi_tx       (o_spi_tx),
		.o_spi_tx_dv    (o_spi_tx_dv),
		.o_done         (spi_done),
		.o_rx_byte      (spi_rx_byte)
	);

	reply_sender u_tx (
		.clk          (clk),
		.rstn         (rstn),
		.i_reply_load (reply_load),
		.i_reply_word (reply_word),
		.i_out_ready  (i_out_ready),
		.o_out_valid  (o_out_valid),
		.o_out_data   (o_out_data)
	);

endmodule

// File: sim/tb_cmdproc.sv
// Testbench for the host command processor
// Applies a table of command frames, models the SPI peripheral and
// checks reply words, SPI strobes, chip selects and the PLL pulse

`timescale 1ns/1ps
`include "cmdproc_settings.svh"

module tb_cmdproc;
	import cmdproc_pkg::*;

	localparam int NCMD  = 11;
	localparam int LIMIT = NCMD * 200;

	logic                  clk = 1'b0;
	logic                  rstn;
	logic                  i_in_valid;
	byte_t                 i_in_data;
	logic                  o_in_ready;
	logic                  i_out_ready;
	logic                  o_out_valid;
	word_t                 o_out_data;
	logic                  o_pll_reset;
	logic [`SPI_CHIPS-1:0] o_spi_cs;
	chip_t                 o_miso_sel;
	byte_t                 o_spi_tx;
	logic                  o_spi_tx_dv;
	logic                  i_spi_tx_ready;
	logic                  i_spi_rx_dv;
	byte_t                 i_spi_rx;

	// command table
	frame_t tbl_frame [NCMD];
	logic   tbl_has_reply [NCMD];
	word_t  tbl_reply [NCMD];
	chip_t  tbl_chip [NCMD];
	int     tbl_nspi [NCMD];
	byte_t  tbl_spi [NCMD][4];
	byte_t  tbl_rx [NCMD];
	int     ntbl = 0;

	// observations for the command in flight
	int     cur = 0;
	int     words_seen = 0;
	word_t  got_word = '0;
	int     pll_cycles = 0;
	int     pll_at_accept = 0;
	byte_t  spi_log [8];
	int     nlog = 0;
	logic   cs_seen = 1'b0;
	logic   cs_bad = 1'b0;
	logic   miso_bad = 1'b0;
	logic   waiting_reply = 1'b0;
	logic   hold_pending = 1'b0;
	word_t  held_word = '0;
	int     rx_countdown = 0;
	logic   mon_on = 1'b0;

	int     seed = 17331;
	int     cycles = 0;
	int     checks = 0;
	int     errors = 0;

	cmdproc_top DUT (
		.clk            (clk),
		.rstn           (rstn),
		.i_in_valid     (i_in_valid),
		.i_in_data      (i_in_data),
		.o_in_ready     (o_in_ready),
		.i_out_ready    (i_out_ready),
		.o_out_valid    (o_out_valid),
		.o_out_data     (o_out_data),
		.o_pll_reset    (o_pll_reset),
		.o_spi_cs       (o_spi_cs),
		.o_miso_sel     (o_miso_sel),
		.o_spi_tx       (o_spi_tx),
		.o_spi_tx_dv    (o_spi_tx_dv),
		.i_spi_tx_ready (i_spi_tx_ready),
		.i_spi_rx_dv    (i_spi_rx_dv),
		.i_spi_rx       (i_spi_rx)
	);

	always #4 clk = ~clk;

	// --------------------------------------------------
	// compare tasks
	task automatic check_word(input string name, input word_t got, input word_t exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("** Error: %s = 0x%08h, expected 0x%08h at %0t", name, got, exp, $time);
		end
	endtask

	task automatic check_byte(input string name, input byte_t got, input byte_t exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("** Error: %s = 0x%02h, expected 0x%02h at %0t", name, got, exp, $time);
		end
	endtask

	task automatic check_bit(input string name, input logic got, input logic exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("** Error: %s = 0x%0h, expected 0x%0h at %0t", name, got, exp, $time);
		end
	endtask

	// --------------------------------------------------
	// output back-pressure and SPI peripheral model
	always @(posedge clk) begin
		i_out_ready    <= ($random(seed) % 4) != 0;
		i_spi_tx_ready <= ($random(seed) % 3) == 0; // gaps of a few cycles
		i_spi_rx_dv    <= 1'b0;
		if (rx_countdown > 0) begin
			rx_countdown = rx_countdown - 1;
			if (rx_countdown == 0) begin
				i_spi_rx_dv <= 1'b1;
				i_spi_rx    <= tbl_rx[cur];
			end
		end
		if (o_spi_tx_dv && nlog == tbl_nspi[cur])
			rx_countdown = 2; // read-back a few cycles after the last byte
	end

	// monitor sampled mid-cycle
	always @(negedge clk) begin
		if (mon_on) begin
			if (o_pll_reset)
				pll_cycles++;
			if (hold_pending) begin
				check_bit("o_out_valid", o_out_valid, 1'b1);
				check_word("o_out_data", o_out_data, held_word);
			end
			hold_pending = o_out_valid && !i_out_ready;
			held_word    = o_out_data;
			if (waiting_reply)
				check_bit("o_in_ready", o_in_ready, 1'b0); // stalled until accepted
			if (o_out_valid && i_out_ready) begin
				words_seen++;
				got_word      = o_out_data;
				pll_at_accept = pll_cycles;
				waiting_reply = 1'b0;
			end
			if (o_spi_tx_dv) begin
				check_bit("i_spi_tx_ready", i_spi_tx_ready, 1'b1);
				if (nlog < 8)
					spi_log[nlog] = o_spi_tx;
				nlog++;
			end
			if (o_spi_cs != '1) begin
				if (tbl_nspi[cur] == 0 || ~o_spi_cs != (`SPI_CHIPS'(1) << tbl_chip[cur]))
					cs_bad = 1'b1;
				else
					cs_seen = 1'b1;
				if (o_miso_sel != tbl_chip[cur])
					miso_bad = 1'b1;
			end
		end
	end

	// --------------------------------------------------
	task automatic add_cmd(input byte_t b0, b1, b2, b3, b4, b5, b6, b7,
			input logic has_reply, input word_t reply, input chip_t chip,
			input int nspi, input byte_t s0, s1, s2, s3, input byte_t rx);
		tbl_frame[ntbl]     = {b7, b6, b5, b4, b3, b2, b1, b0}; // byte 0 lowest
		tbl_has_reply[ntbl] = has_reply;
		tbl_reply[ntbl]     = reply;
		tbl_chip[ntbl]      = chip;
		tbl_nspi[ntbl]      = nspi;
		tbl_spi[ntbl][0]    = s0;
		tbl_spi[ntbl][1]    = s1;
		tbl_spi[ntbl][2]    = s2;
		tbl_spi[ntbl][3]    = s3;
		tbl_rx[ntbl]        = rx;
		ntbl++;
	endtask

	task automatic build_table();
		// frame bytes 0..7, then reply flag, word, chip, strobes, tx bytes, read-back
		add_cmd(8'h02, 8'h00, 8'h00, 8'h00, 8'h00, 8'h00, 8'h00, 8'h00, // version
			1'b1, 32'd11, 3'd0, 0, 8'h00, 8'h00, 8'h00, 8'h00, 8'h00);
		add_cmd(8'h04, 8'h00, 8'h00, 8'h00, 8'h00, 8'h00, 8'h00, 8'h00, // unused
			1'b1, 32'd19, 3'd0, 0, 8'h00, 8'h00, 8'h00, 8'h00, 8'h00);
		add_cmd(8'h01, 8'h00, 8'h00, 8'h00, 8'h00, 8'h00, 8'h00, 8'h00, // pll reset
			1'b1, 32'd33, 3'd0, 0, 8'h00, 8'h00, 8'h00, 8'h00, 8'h00);
		add_cmd(8'h03, 8'h0d, 8'ha1, 8'ha2, 8'ha3, 8'ha4, 8'h5e, 8'h02, // spi with 2 bytes
			1'b1, 32'h5c, 3'd5, 2, 8'ha1, 8'ha3, 8'h00, 8'h00, 8'h5c);
		add_cmd(8'h03, 8'h00, 8'hb1, 8'hb2, 8'hb3, 8'hb4, 8'h00, 8'h03, // spi with 3 bytes
			1'b1, 32'h3e, 3'd0, 3, 8'hb1, 8'hb2, 8'hb3, 8'h00, 8'h3e);
		add_cmd(8'h09, 8'h01, 8'h02, 8'h03, 8'h04, 8'h05, 8'h06, 8'h07, // unknown
			1'b0, 32'h0, 3'd0, 0, 8'h00, 8'h00, 8'h00, 8'h00, 8'h00);
		add_cmd(8'h03, 8'h07, 8'hc1, 8'hc2, 8'hc3, 8'hc4, 8'h00, 8'h04, // spi with 4 bytes
			1'b1, 32'he7, 3'd7, 4, 8'hc1, 8'hc2, 8'hc3, 8'hc4, 8'he7);
		add_cmd(8'h02, 8'hff, 8'hff, 8'hff, 8'hff, 8'hff, 8'hff, 8'hff, // version
			1'b1, 32'd11, 3'd0, 0, 8'h00, 8'h00, 8'h00, 8'h00, 8'h00);
		add_cmd(8'h00, 8'h03, 8'h11, 8'h22, 8'h33, 8'h44, 8'h55, 8'h04, // opcode 0 dropped
			1'b0, 32'h0, 3'd0, 0, 8'h00, 8'h00, 8'h00, 8'h00, 8'h00);
		add_cmd(8'h03, 8'h03, 8'hd1, 8'hd2, 8'hd3, 8'hd4, 8'h00, 8'h07, // odd count sends 3
			1'b1, 32'h81, 3'd3, 3, 8'hd1, 8'hd2, 8'hd3, 8'h00, 8'h81);
		add_cmd(8'h01, 8'h00, 8'h00, 8'h00, 8'h00, 8'h00, 8'h00, 8'h00, // pll reset
			1'b1, 32'd33, 3'd0, 0, 8'h00, 8'h00, 8'h00, 8'h00, 8'h00);
	endtask

	task automatic send_frame(input frame_t f);
		int i;
		for (i = 0; i < `FRAME_BYTES; i++) begin
			@(posedge clk);
			i_in_valid <= 1'b1;
			i_in_data  <= f[i];
			do @(negedge clk); while (!o_in_ready); // taken on the next edge
		end
		@(posedge clk);
		i_in_valid <= 1'b0;
	endtask

	task automatic run_cmd(input int k);
		byte_t exp_pll;
		int    i;
		@(posedge clk);
		cur           = k;
		words_seen    = 0;
		pll_cycles    = 0;
		pll_at_accept = 0;
		nlog          = 0;
		cs_seen       = 1'b0;
		cs_bad        = 1'b0;
		miso_bad      = 1'b0;
		mon_on        = 1'b1;
		send_frame(tbl_frame[k]);
		waiting_reply = tbl_has_reply[k];
		if (tbl_has_reply[k]) begin
			do @(negedge clk); while (words_seen == 0);
		end
		do @(negedge clk); while (!o_in_ready);
		repeat (4) @(negedge clk); // room for a stray word
		exp_pll = (tbl_frame[k][0] == 8'd1) ? 8'd1 : 8'd0;
		check_byte("o_out_valid words", byte_t'(words_seen), tbl_has_reply[k] ? 8'd1 : 8'd0);
		if (tbl_has_reply[k]) begin
			check_word("o_out_data", got_word, tbl_reply[k]);
			check_byte("o_pll_reset cycles before reply", byte_t'(pll_at_accept), exp_pll);
		end
		check_byte("o_pll_reset cycles", byte_t'(pll_cycles), exp_pll);
		check_byte("o_spi_tx_dv strobes", byte_t'(nlog), byte_t'(tbl_nspi[k]));
		for (i = 0; i < tbl_nspi[k] && i < nlog; i++)
			check_byte("o_spi_tx", spi_log[i], tbl_spi[k][i]);
		check_bit("o_spi_cs selected line low", cs_seen, tbl_nspi[k] != 0);
		check_bit("o_spi_cs wrong line low", cs_bad, 1'b0);
		check_bit("o_miso_sel mismatch", miso_bad, 1'b0);
	endtask

	// --------------------------------------------------
	always @(posedge clk) begin
		cycles++;
		if (cycles >= LIMIT) begin
			$display("timeout: run did not finish within %0d cycles", LIMIT);
			$display("CHECKS FAILED");
			$finish;
		end
	end

	initial begin
		int k;
		rstn           = 1'b0;
		i_in_valid     = 1'b0;
		i_in_data      = '0;
		i_out_ready    = 1'b0;
		i_spi_tx_ready = 1'b0;
		i_spi_rx_dv    = 1'b0;
		i_spi_rx       = '0;
		build_table();
		repeat (2) @(posedge clk);
		rstn <= 1'b1;
		@(negedge clk);
		check_bit("o_in_ready", o_in_ready, 1'b1);
		check_bit("o_out_valid", o_out_valid, 1'b0);
		check_byte("o_spi_cs", byte_t'(o_spi_cs), 8'hff);
		check_bit("o_pll_reset", o_pll_reset, 1'b0);
		for (k = 0; k < ntbl; k++)
			run_cmd(k);
		$display("commands: %0d, checks: %0d, errors: %0d", ntbl, checks, errors);
		if (errors == 0)
			$display("ALL CHECKS PASSED");
		else
			$display("CHECKS FAILED");
		$finish;
	end

endmodule

// File: sim.f
+incdir+source
source/cmdproc_pkg.sv
source/frame_receiver.sv
source/spi_sequencer.sv
source/cmd_dispatch.sv
source/reply_sender.sv
source/cmdproc_top.sv
sim/tb_cmdproc.sv

// File: Makefile
# Verilator build and run for the host command processor

VERILATOR ?= verilator
TOP       ?= tb_cmdproc
FILELIST  ?= sim.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -qx "ALL CHECKS PASSED" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
